//--- regSeq_config.svh
`ifndef REGSEQ_CONFIG_SVH
`define REGSEQ_CONFIG_SVH

// width of one register value
// the instruction word uses the same width
`define REGSEQ_DATA_W 16

// register index width
// must cover REGSEQ_NREGS entries
`define REGSEQ_IDX_W 3

// number of entries in the register file
`define REGSEQ_NREGS 8

// immediate field width
// sits in the low bits of the instruction word
`define REGSEQ_IMM_W 6

`endif

//--- regSeqPkg.sv
`include "regSeq_config.svh"

package regSeqPkg;

	// one register value
	typedef logic [`REGSEQ_DATA_W-1:0] dataWord;

	// register file address
	typedef logic [`REGSEQ_IDX_W-1:0] regIdx;

	// instruction word layout
	//   [15:12] sequence code
	//   [11]    byte flag
	//   [10:9]  alu op
	//   [8:6]   a index
	//   [5:3]   b index
	//   [5:0]   immediate, shares bits with b index
	typedef logic [`REGSEQ_DATA_W-1:0] instrWord;

	// one instruction takes four phases
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phaseT;

	// register cycle to run
	// RD reads, LD writes, UP reads then writes back
	typedef enum logic [3:0] {
		NONE    = 4'd0,
		RDA_RDB = 4'd1,
		LDA_RDB = 4'd2,
		LDA_UPB = 4'd3,
		RDA_UPB = 4'd4,
		LDA_IMM = 4'd5,
		RDA_IMM = 4'd6,
		UPA_RDB = 4'd7,
		UPA_IMM = 4'd8,
		RDB     = 4'd9
	} regSeqT;

	// operations for the UPA forms
	typedef enum logic [1:0] {
		ADD,
		SUB,
		AND,
		XOR
	} aluOpT;

endpackage

//--- regPortIf.sv
// one port of the register file
// en alone reads, en with wen writes
interface regPortIf import regSeqPkg::*; ();

	// cycle strobes from the sequencer
	logic en;
	logic wen;
	regIdx idx;

	// write value from the execute unit
	dataWord wdata;

	// registered read value, holds until the next read
	dataWord rdata;

	// sequencer runs the cycle
	modport sequencer (output en, wen, idx);

	// register file serves the cycle
	modport file (input en, wen, idx, wdata, output rdata);

	// execute unit turns read data into write data
	modport datapath (input rdata, output wdata);

endinterface

//--- opxIf.sv
`include "regSeq_config.svh"

// decoded instruction fields
// stable from DECODE through COMMIT
interface opxIf import regSeqPkg::*; ();

	regSeqT seqCode;
	logic byteOp;
	regIdx aIdx;
	regIdx bIdx;
	logic [`REGSEQ_IMM_W-1:0] imm;
	aluOpT aluOp;

	modport decoder (output seqCode, byteOp, aIdx, bIdx, imm, aluOp);

	// sequencer needs the cycle kind and the addresses
	modport sequencer (input seqCode, aIdx, bIdx);

	// execute unit needs everything that shapes write data
	modport datapath (input seqCode, byteOp, imm, aluOp);

endinterface

//--- phaseGenerator.sv
// four-phase instruction cycle
// waits in FETCH while run is low
module phaseGenerator import regSeqPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic run,
	output phaseT phase,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	phaseT nextPhase;

	// run only matters at the start of an instruction
	always_comb begin
		case (phase)
			FETCH: nextPhase = run ? DECODE : FETCH;
			DECODE: nextPhase = EXECUTE;
			EXECUTE: nextPhase = COMMIT;
			default: nextPhase = FETCH;
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= FETCH;
		end else begin
			phase <= nextPhase;
		end
	end

	// one-hot strobes, each high for its whole cycle
	assign fetch = (phase == FETCH);
	assign decode = (phase == DECODE);
	assign execute = (phase == EXECUTE);
	assign commit = (phase == COMMIT);

endmodule

//--- opxDecoder.sv
// holds the instruction taken in FETCH
// splits it into the fields the other blocks use
module opxDecoder import regSeqPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic fetch,
	input instrWord instr,
	opxIf.decoder opx
);

	instrWord instrR;

	// sampled on the edge that ends FETCH
	// cleared so the first decode after reset is a no-op
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instrR <= '0;
		end else if (fetch) begin
			instrR <= instr;
		end
	end

	// sequence code
	// codes past RDB are undefined and run as NONE
	always_comb begin
		if (instrR[15:12] > RDB) begin
			opx.seqCode = NONE;
		end else begin
			opx.seqCode = regSeqT'(instrR[15:12]);
		end
	end

	// byte select for loads, step size for pointer updates
	assign opx.byteOp = instrR[11];

	assign opx.aluOp = aluOpT'(instrR[10:9]);

	// register addresses
	assign opx.aIdx = instrR[8:6];
	assign opx.bIdx = instrR[5:3];

	// immediate overlaps b index
	// only the IMM forms look at it
	assign opx.imm = instrR[5:0];

endmodule

//--- registerSequencer.sv
// turns the sequence code into register port cycles
//   F     D     E     C     F
// rd en       -----
// wr en             -----
// wen               -----
// flags latched on the edge that ends DECODE
module registerSequencer import regSeqPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic fetch,
	input logic decode,
	input logic execute,
	input logic commit,
	opxIf.sequencer opx,
	regPortIf.sequencer portA,
	regPortIf.sequencer portB
);

	// bit order {aRead, aWrite, bRead, bWrite}
	logic [3:0] pattern;
	logic [3:0] flags;

	logic aRead;
	logic aWrite;
	logic bRead;
	logic bWrite;

	// enable pattern per sequence code
	always_comb begin
		case (opx.seqCode)
			RDA_RDB: pattern = 4'b1010;
			LDA_RDB: pattern = 4'b0110;
			LDA_UPB: pattern = 4'b0111;
			RDA_UPB: pattern = 4'b1011;
			LDA_IMM: pattern = 4'b0100;
			RDA_IMM: pattern = 4'b1000;
			UPA_RDB: pattern = 4'b1110;
			UPA_IMM: pattern = 4'b1100;
			RDB: pattern = 4'b0010;
			// NONE reads and writes nothing
			default: pattern = 4'b0000;
		endcase
	end

	// cleared every FETCH cycle
	// so a stall in FETCH keeps all ports idle
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			flags <= '0;
		end else if (fetch) begin
			flags <= '0;
		end else if (decode) begin
			flags <= pattern;
		end
	end

	assign aRead = flags[3];
	assign aWrite = flags[2];
	assign bRead = flags[1];
	assign bWrite = flags[0];

	// reads run in EXECUTE, writes in COMMIT
	// an UP form uses both on the same port
	assign portA.en = (aRead & execute) | (aWrite & commit);
	assign portA.wen = aWrite & commit;
	assign portB.en = (bRead & execute) | (bWrite & commit);
	assign portB.wen = bWrite & commit;

	// addresses stay put for the whole instruction
	assign portA.idx = opx.aIdx;
	assign portB.idx = opx.bIdx;

endmodule

//--- registerFile.sv
`include "regSeq_config.svh"

// general registers with two independent ports
// all accesses on the rising edge
module registerFile import regSeqPkg::*; (
	input logic CLK,
	input logic RESET,
	regPortIf.file portA,
	regPortIf.file portB
);

	dataWord regs [`REGSEQ_NREGS];

	// writes land on the edge that ends COMMIT
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < `REGSEQ_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (portA.en && portA.wen) begin
				regs[portA.idx] <= portA.wdata;
			end
			// later assignment takes effect
			// so port B wins when both name the same register
			if (portB.en && portB.wen) begin
				regs[portB.idx] <= portB.wdata;
			end
		end
	end

	// port A read
	// updates on the edge that ends EXECUTE, then holds
	always_ff @(posedge CLK) begin
		if (portA.en && !portA.wen) begin
			portA.rdata <= regs[portA.idx];
		end
	end

	// port B read
	always_ff @(posedge CLK) begin
		if (portB.en && !portB.wen) begin
			portB.rdata <= regs[portB.idx];
		end
	end

endmodule

//--- executeUnit.sv
// forms the write data for both ports during COMMIT
// works on the data read in EXECUTE
module executeUnit import regSeqPkg::*; (
	opxIf.datapath opx,
	regPortIf.datapath portA,
	regPortIf.datapath portB
);

	dataWord immExt;
	dataWord byteSel;
	logic a0;

	// two-operand alu for the UPA forms
	function automatic dataWord aluResult(aluOpT op, dataWord x, dataWord y);
		case (op)
			ADD: return x + y;
			SUB: return x - y;
			AND: return x & y;
			default: return x ^ y;
		endcase
	endfunction

	// immediate is always unsigned
	assign immExt = dataWord'(opx.imm);

	// low bit of the B value picks the byte
	assign a0 = portB.rdata[0];

	// a0 clear takes the high byte
	assign byteSel = a0 ? dataWord'(portB.rdata[7:0]) : dataWord'(portB.rdata[15:8]);

	// port A write value
	// forms that do not write A pass the read value through
	always_comb begin
		case (opx.seqCode)
			LDA_RDB, LDA_UPB: portA.wdata = opx.byteOp ? byteSel : portB.rdata;
			LDA_IMM: portA.wdata = immExt;
			UPA_RDB: portA.wdata = aluResult(opx.aluOp, portA.rdata, portB.rdata);
			UPA_IMM: portA.wdata = aluResult(opx.aluOp, portA.rdata, immExt);
			default: portA.wdata = portA.rdata;
		endcase
	end

	// port B write value
	// pointer steps by one byte or one word
	always_comb begin
		case (opx.seqCode)
			LDA_UPB, RDA_UPB: begin
				portB.wdata = portB.rdata + (opx.byteOp ? dataWord'(1) : dataWord'(2));
			end
			default: portB.wdata = portB.rdata;
		endcase
	end

endmodule

//--- regCore.sv
// register cycle core
// phase control, decode, sequencing, registers and write data
module regCore import regSeqPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic run,
	input instrWord instr,
	output logic fetch,
	output dataWord regAData,
	output dataWord regBData,
	output logic aWrite,
	output logic bWrite
);

	logic decode;
	logic execute;
	logic commit;

	regPortIf portA();
	regPortIf portB();
	opxIf opx();

	// phase value itself is not needed here, strobes are enough
	phaseGenerator phaseGen (
		.CLK(CLK),
		.RESET(RESET),
		.run(run),
		.phase(),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	opxDecoder decoder (
		.CLK(CLK),
		.RESET(RESET),
		.fetch(fetch),
		.instr(instr),
		.opx(opx)
	);

	registerSequencer sequencer (
		.CLK(CLK),
		.RESET(RESET),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.opx(opx),
		.portA(portA),
		.portB(portB)
	);

	registerFile regFile (
		.CLK(CLK),
		.RESET(RESET),
		.portA(portA),
		.portB(portB)
	);

	executeUnit execUnit (
		.opx(opx),
		.portA(portA),
		.portB(portB)
	);

	// read data as it leaves the register file
	assign regAData = portA.rdata;
	assign regBData = portB.rdata;

	// write strobes, one pulse in COMMIT
	assign aWrite = portA.wen;
	assign bWrite = portB.wen;

endmodule

//--- tbClock.sv
// clock and reset for the testbench
// period of 100, reset held for the first 8 rising edges
module tbClock (
	output logic CLK,
	output logic RESET
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		RESET = 1'b1;
		repeat (8) @(posedge CLK);
		RESET <= 1'b0;
	end

endmodule

//--- regCoreTb.sv
`include "regSeq_config.svh"

// testbench for the register cycle core
// stimulus on the rising edge, checks on the falling edge
module regCoreTb import regSeqPkg::*; ();

	// upper bound on instructions over all six tests
	localparam int INSTR_COUNT = 130;
	// reset plus stall cycles plus slack
	localparam int CYCLE_LIMIT = INSTR_COUNT * 4 + 100;

	// expected behavior of one instruction
	typedef struct packed {
		logic rdA;
		logic wrA;
		logic rdB;
		logic wrB;
		dataWord valA;
		dataWord valB;
		dataWord newA;
		dataWord newB;
	} refT;

	logic CLK;
	logic RESET;
	logic run;
	instrWord instr;
	logic fetch;
	dataWord regAData;
	dataWord regBData;
	logic aWrite;
	logic bWrite;

	// register contents as the model sees them
	logic [`REGSEQ_NREGS-1:0][`REGSEQ_DATA_W-1:0] model;
	phaseT expPhase;
	refT cur;
	dataWord heldA;
	dataWord heldB;
	logic knownA;
	logic knownB;

	// instruction in flight, for the write addresses
	instrWord lastInstr;

	int issued = 0;
	int taken = 0;
	int retired = 0;
	int checks = 0;
	int errors = 0;
	int startErrors = 0;
	int testCount = 0;
	int cycles = 0;
	integer seed = 32'h43aa_c70a;
	string testName = "reset";

	tbClock clockGen (
		.CLK(CLK),
		.RESET(RESET)
	);

	regCore DUT (
		.CLK(CLK),
		.RESET(RESET),
		.run(run),
		.instr(instr),
		.fetch(fetch),
		.regAData(regAData),
		.regBData(regBData),
		.aWrite(aWrite),
		.bWrite(bWrite)
	);

	// register-only forms, B index in bits 5..3
	function automatic instrWord makeInstr(logic [3:0] code, logic byteOp, logic [1:0] op,
			regIdx a, regIdx b);
		return {code, byteOp, op, a, b, 3'b000};
	endfunction

	// immediate forms, immediate in bits 5..0
	function automatic instrWord makeImm(logic [3:0] code, logic [1:0] op, regIdx a,
			logic [5:0] imm);
		return {code, 1'b0, op, a, imm};
	endfunction

	// what one instruction reads and writes, given the register contents
	function automatic refT refModel(instrWord w, logic [7:0][15:0] regs);
		refT r;
		logic [3:0] code;
		logic byteOp;
		logic [1:0] op;
		logic [2:0] ai;
		logic [2:0] bi;
		logic [15:0] imm;
		logic [15:0] second;
		code = w[15:12];
		byteOp = w[11];
		op = w[10:9];
		ai = w[8:6];
		bi = w[5:3];
		imm = {10'd0, w[5:0]};
		r = '0;
		// RD reads, LD writes, UP does both
		case (code)
			4'd1: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b1010;
			4'd2: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b0110;
			4'd3: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b0111;
			4'd4: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b1011;
			4'd5: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b0100;
			4'd6: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b1000;
			4'd7: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b1110;
			4'd8: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b1100;
			4'd9: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b0010;
			default: {r.rdA, r.wrA, r.rdB, r.wrB} = 4'b0000;
		endcase
		r.valA = regs[ai];
		r.valB = regs[bi];
		second = (code == 4'd8) ? imm : r.valB;
		case (code)
			4'd2, 4'd3: begin
				if (!byteOp) begin
					r.newA = r.valB;
				end else if (r.valB[0]) begin
					r.newA = {8'h00, r.valB[7:0]};
				end else begin
					r.newA = {8'h00, r.valB[15:8]};
				end
			end
			4'd5: r.newA = imm;
			4'd7, 4'd8: begin
				case (op)
					2'd0: r.newA = r.valA + second;
					2'd1: r.newA = r.valA - second;
					2'd2: r.newA = r.valA & second;
					default: r.newA = r.valA ^ second;
				endcase
			end
			default: r.newA = r.valA;
		endcase
		// pointer step of one byte or one word
		r.newB = r.valB + (byteOp ? 16'd1 : 16'd2);
		return r;
	endfunction

	function automatic regIdx instrIdxA();
		return lastInstr[8:6];
	endfunction

	function automatic regIdx instrIdxB();
		return lastInstr[5:3];
	endfunction

	task automatic checkValue(string what, logic [15:0] expected, logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s %s expected %h, actual %h", testName, what, expected,
				actual);
		end
	endtask

	// follows the phases on its own and checks every falling edge
	always @(negedge CLK) begin
		if (RESET) begin
			expPhase = FETCH;
			model = '0;
			knownA = 1'b0;
			knownB = 1'b0;
		end else begin
			checkValue("fetch", {15'd0, expPhase == FETCH}, {15'd0, fetch});
			if (expPhase == COMMIT) begin
				checkValue("aWrite", {15'd0, cur.wrA}, {15'd0, aWrite});
				checkValue("bWrite", {15'd0, cur.wrB}, {15'd0, bWrite});
				// read data settled on the edge that ended EXECUTE
				if (cur.rdA) begin
					heldA = cur.valA;
					knownA = 1'b1;
				end
				if (cur.rdB) begin
					heldB = cur.valB;
					knownB = 1'b1;
				end
				if (knownA) begin
					checkValue("regAData", heldA, regAData);
				end
				if (knownB) begin
					checkValue("regBData", heldB, regBData);
				end
				// B goes last so it wins a shared index
				if (cur.wrA) begin
					model[instrIdxA()] = cur.newA;
				end
				if (cur.wrB) begin
					model[instrIdxB()] = cur.newB;
				end
				retired++;
				expPhase = FETCH;
			end else begin
				checkValue("aWrite", 16'd0, {15'd0, aWrite});
				checkValue("bWrite", 16'd0, {15'd0, bWrite});
				case (expPhase)
					FETCH: begin
						if (run) begin
							cur = refModel(instr, model);
							lastInstr = instr;
							taken++;
							expPhase = DECODE;
						end
					end
					DECODE: expPhase = EXECUTE;
					default: expPhase = COMMIT;
				endcase
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the instruction stream did not finish", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// present one instruction in FETCH and wait for its COMMIT
	task automatic runInstr(instrWord w);
		@(posedge CLK);
		instr <= w;
		run <= 1'b1;
		issued++;
		wait (taken == issued);
		@(posedge CLK);
		run <= 1'b0;
		wait (retired == issued);
	endtask

	// run stays low, instr changes to show it is ignored
	task automatic stallCycles(int n, instrWord w);
		@(posedge CLK);
		instr <= w;
		repeat (n) @(posedge CLK);
	endtask

	task automatic beginTest(string name);
		testName = name;
		startErrors = errors;
		testCount++;
	endtask

	task automatic endTest();
		$display("test %s finished with %0d errors", testName, errors - startErrors);
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd2;
		regIdx ra;
		regIdx rb;
		logic [1:0] opSel;
		logic [5:0] k;
		run = 1'b0;
		instr = '0;
		wait (!RESET);

		beginTest("resetState");
		stallCycles(10, makeImm(LDA_IMM, 2'd0, 3'd1, 6'h3f));
		for (int i = 0; i < 8; i += 2) begin
			runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, regIdx'(i), regIdx'(i + 1)));
		end
		endTest();

		beginTest("immediates");
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			runInstr(makeImm(LDA_IMM, 2'd0, regIdx'(i), rnd[5:0]));
		end
		for (int i = 0; i < 8; i++) begin
			runInstr(makeImm(RDA_IMM, 2'd0, regIdx'(i), 6'd0));
			runInstr(makeInstr(RDB, 1'b0, 2'd0, 3'd0, regIdx'(i)));
		end
		endTest();

		beginTest("aluUpdates");
		for (int op = 0; op < 4; op++) begin
			opSel = op[1:0];
			repeat (3) begin
				rnd = $random(seed);
				rnd2 = $random(seed);
				ra = rnd[2:0];
				rb = rnd[5:3];
				runInstr(makeImm(LDA_IMM, 2'd0, ra, rnd[11:6]));
				runInstr(makeImm(LDA_IMM, 2'd0, rb, rnd[17:12]));
				runInstr(makeInstr(UPA_RDB, 1'b0, opSel, ra, rb));
				runInstr(makeImm(UPA_IMM, opSel, ra, rnd2[5:0]));
				runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, ra, rb));
			end
		end
		endTest();

		beginTest("bytePointer");
		for (int c = 0; c < 4; c++) begin
			rnd = $random(seed);
			// zero minus k fills the high byte, k[0] becomes A0
			k = {1'b1, rnd[3:0], c[0]};
			runInstr(makeImm(LDA_IMM, 2'd0, 3'd1, 6'd0));
			runInstr(makeImm(UPA_IMM, 2'd1, 3'd1, k));
			runInstr(makeInstr(LDA_UPB, c[1], 2'd0, 3'd3, 3'd1));
			runInstr(makeInstr(RDA_UPB, c[1], 2'd0, 3'd3, 3'd1));
			runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, 3'd3, 3'd1));
		end
		endTest();

		beginTest("noneAndIllegal");
		for (int code = 9; code < 16; code++) begin
			rnd = $random(seed);
			// 9 stands in for NONE here
			runInstr({(code == 9) ? 4'd0 : code[3:0], rnd[11:0]});
		end
		for (int i = 0; i < 8; i += 2) begin
			runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, regIdx'(i), regIdx'(i + 1)));
		end
		runInstr(makeImm(LDA_IMM, 2'd0, 3'd5, 6'h2d));
		runInstr(makeInstr(LDA_UPB, 1'b0, 2'd0, 3'd5, 3'd5));
		runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, 3'd5, 3'd5));
		endTest();

		beginTest("pausing");
		runInstr(makeImm(LDA_IMM, 2'd0, 3'd6, 6'h15));
		stallCycles(6, makeImm(LDA_IMM, 2'd0, 3'd6, 6'h2a));
		runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, 3'd6, 3'd6));
		stallCycles(6, makeImm(UPA_IMM, 2'd0, 3'd6, 6'h01));
		runInstr(makeImm(UPA_IMM, 2'd0, 3'd6, 6'h0b));
		runInstr(makeInstr(RDA_RDB, 1'b0, 2'd0, 3'd6, 3'd6));
		endTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+.
regSeqPkg.sv
regPortIf.sv
opxIf.sv
phaseGenerator.sv
opxDecoder.sv
registerSequencer.sv
registerFile.sv
executeUnit.sv
regCore.sv
tbClock.sv
regCoreTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports success
verilator --binary --timing -f build.f --top-module regCoreTb -o regCoreSim &&
	./obj_dir/regCoreSim | tee /dev/stderr | grep -q "Simulation finished: PASS" ||
	exit 1
